/* verilog/aes_pkg.sv */
package aes_pkg;

    localparam int NB_BYTE      = 8;
    localparam int N_BYTES      = 16;
    localparam int NB_WORD      = 32;
    localparam int NB_STATE     = N_BYTES * NB_BYTE;
    localparam int NB_KEY       = 256;
    localparam int N_ROUNDS     = 14;
    localparam int N_STAGES     = N_ROUNDS + 1;            // Round 0 is AddRoundKey only.
    localparam int NB_ROUND_CNT = $clog2(N_STAGES + 1);

    typedef logic [NB_STATE-1:0]                aes_block_t;
    typedef logic [NB_KEY-1:0]                  aes_key_t;
    typedef aes_block_t [N_STAGES-1:0]          aes_round_keys_t;

    // Forward S-box, entry 0 first.
    localparam logic [0:255][NB_BYTE-1:0] SBOX = {
        256'h637c777bf26b6fc53001672bfed7ab76ca82c97dfa5947f0add4a2af9ca472c0,
        256'hb7fd9326363ff7cc34a5e5f171d8311504c723c31896059a071280e2eb27b275,
        256'h09832c1a1b6e5aa0523bd6b329e32f8453d100ed20fcb15b6acbbe394a4c58cf,
        256'hd0efaafb434d338545f9027f503c9fa851a3408f929d38f5bcb6da2110fff3d2,
        256'hcd0c13ec5f974417c4a77e3d645d197360814fdc222a908846eeb814de5e0bdb,
        256'he0323a0a4906245cc2d3ac629195e479e7c8376d8dd54ea96c56f4ea657aae08,
        256'hba78252e1ca6b4c6e8dd741f4bbd8b8a703eb5664803f60e613557b986c11d9e,
        256'he1f8981169d98e949b1e87e9ce5528df8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [NB_BYTE-1:0] sbox(input logic [NB_BYTE-1:0] b);
        return SBOX[b];
    endfunction

    // Multiply by x in GF(2^8).
    function automatic logic [NB_BYTE-1:0] xtime(input logic [NB_BYTE-1:0] b);
        return {b[NB_BYTE-2:0], 1'b0} ^ (b[NB_BYTE-1] ? 8'h1b : 8'h00);
    endfunction

    // Byte 0 sits in the top bits, as in the FIPS-197 vectors.
    function automatic aes_block_t sub_bytes(input aes_block_t blk);
        aes_block_t res;
        for (int i = 0; i < N_BYTES; i++)
        begin
            res[NB_STATE-1-NB_BYTE*i -: NB_BYTE] = sbox(blk[NB_STATE-1-NB_BYTE*i -: NB_BYTE]);
        end
        return res;
    endfunction

    function automatic aes_block_t shift_rows(input aes_block_t blk);
        aes_block_t res;
        int         src;
        for (int i = 0; i < N_BYTES; i++)
        begin
            // Row i%4 rotates left by its own index.
            src = (i % 4) + 4 * (((i / 4) + (i % 4)) % 4);
            res[NB_STATE-1-NB_BYTE*i -: NB_BYTE] = blk[NB_STATE-1-NB_BYTE*src -: NB_BYTE];
        end
        return res;
    endfunction

    function automatic aes_block_t mix_columns(input aes_block_t blk);
        aes_block_t              res;
        logic [NB_WORD-1:0]      col;
        logic [NB_BYTE-1:0]      a0;
        logic [NB_BYTE-1:0]      a1;
        logic [NB_BYTE-1:0]      a2;
        logic [NB_BYTE-1:0]      a3;
        for (int c = 0; c < 4; c++)
        begin
            col = blk[NB_STATE-1-NB_WORD*c -: NB_WORD];
            a0  = col[31:24];
            a1  = col[23:16];
            a2  = col[15:8];
            a3  = col[7:0];
            col[31:24] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            col[23:16] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            col[15:8]  = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            col[7:0]   = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
            res[NB_STATE-1-NB_WORD*c -: NB_WORD] = col;
        end
        return res;
    endfunction

endpackage

/* verilog/aes_key_expander.sv */
`timescale 1ns/100ps

module aes_key_expander
(
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  aes_pkg::aes_key_t           i_key,
    input  logic                        i_key_load,
    output aes_pkg::aes_round_keys_t    o_round_keys,
    output logic                        o_key_ready
);

    import aes_pkg::*;

    logic [0:7][NB_WORD-1:0]        window;         // w[4k] .. w[4k+7].
    logic [0:3][NB_WORD-1:0]        next_words;
    logic [NB_WORD-1:0]             temp;
    logic [NB_BYTE-1:0]             rcon;
    logic [NB_ROUND_CNT-1:0]        round_cnt;
    logic                           busy;
    logic                           load_accept;
    logic                           step;
    aes_round_keys_t                shadow;

    function automatic logic [NB_WORD-1:0] sub_word(input logic [NB_WORD-1:0] w);
        logic [NB_WORD-1:0] res;
        for (int i = 0; i < 4; i++)
        begin
            res[NB_WORD-1-NB_BYTE*i -: NB_BYTE] = sbox(w[NB_WORD-1-NB_BYTE*i -: NB_BYTE]);
        end
        return res;
    endfunction

    assign load_accept = i_key_load && !busy;
    assign step        = busy && (round_cnt < NB_ROUND_CNT'(N_STAGES));

    // Next four schedule words. Even steps start on a multiple of eight.
    always_comb
    begin
        temp = window[7];
        if (!round_cnt[0])
        begin
            temp = sub_word({temp[23:0], temp[31:24]}) ^ {rcon, 24'h0};
        end
        else
        begin
            temp = sub_word(temp);
        end
        next_words[0] = window[0] ^ temp;
        next_words[1] = window[1] ^ next_words[0];
        next_words[2] = window[2] ^ next_words[1];
        next_words[3] = window[3] ^ next_words[2];
    end

    always_ff @(posedge i_clock)
    begin
        if (load_accept)
        begin
            window <= i_key;
            rcon   <= 8'h01;
        end
        else if (step)
        begin
            shadow[round_cnt] <= window[0:3];   // Oldest four words are round key k.
            window            <= {window[4:7], next_words};
            if (!round_cnt[0])
            begin
                rcon <= xtime(rcon);
            end
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            busy         <= 1'b0;
            round_cnt    <= '0;
            o_key_ready  <= 1'b0;
            o_round_keys <= '0;
        end
        else if (load_accept)
        begin
            busy        <= 1'b1;
            round_cnt   <= '0;
            o_key_ready <= 1'b0;
        end
        else if (step)
        begin
            round_cnt <= round_cnt + 1'b1;
        end
        else if (busy)
        begin
            // All fifteen keys built, swap them in together.
            busy         <= 1'b0;
            o_key_ready  <= 1'b1;
            o_round_keys <= shadow;
        end
    end

endmodule

/* verilog/aes_round_stage.sv */
`timescale 1ns/100ps

module aes_round_stage
#(
    parameter int ROUND_INDEX = 0
)
(
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  aes_pkg::aes_block_t     i_state,
    input  aes_pkg::aes_block_t     i_data,
    input  logic                    i_valid,
    input  aes_pkg::aes_block_t     i_round_key,
    output aes_pkg::aes_block_t     o_state,
    output aes_pkg::aes_block_t     o_data,
    output logic                    o_valid
);

    import aes_pkg::*;

    aes_block_t     sub_state;
    aes_block_t     shift_state;
    aes_block_t     mix_state;
    aes_block_t     next_state;

    assign sub_state   = sub_bytes(i_state);
    assign shift_state = shift_rows(sub_state);
    assign mix_state   = mix_columns(shift_state);

    // Round type depends only on the index.
    always_comb
    begin
        if (ROUND_INDEX == 0)
        begin
            next_state = i_state ^ i_round_key;         // Initial whitening.
        end
        else if (ROUND_INDEX == N_ROUNDS)
        begin
            next_state = shift_state ^ i_round_key;     // No MixColumns in the last round.
        end
        else
        begin
            next_state = mix_state ^ i_round_key;
        end
    end

    // Payload only moves with a valid block.
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_state <= next_state;
            o_data  <= i_data;
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

endmodule

/* verilog/aes_round_ladder_xor_data.sv */
`timescale 1ns/100ps

module aes_round_ladder_xor_data
(
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  aes_pkg::aes_block_t         i_state,
    input  aes_pkg::aes_block_t         i_data,
    input  logic                        i_valid,
    input  aes_pkg::aes_round_keys_t    i_round_keys,
    output aes_pkg::aes_block_t         o_state,
    output aes_pkg::aes_block_t         o_data,
    output logic                        o_valid
);

    import aes_pkg::*;

    // Entry 0 is the ladder input, entry k+1 the output of stage k.
    aes_block_t     state_bus [0:N_STAGES];
    aes_block_t     data_bus  [0:N_STAGES];
    logic           valid_bus [0:N_STAGES];

    assign state_bus[0] = i_state;
    assign data_bus[0]  = i_data;
    assign valid_bus[0] = i_valid;

    for (genvar ii = 0; ii < N_STAGES; ii++)
    begin : gen_round_stage
        aes_round_stage
        #(
            .ROUND_INDEX    (ii)
        )
        u_round_stage
        (
            .i_clock        (i_clock),
            .i_rst_n        (i_rst_n),
            .i_state        (state_bus[ii]),
            .i_data         (data_bus[ii]),
            .i_valid        (valid_bus[ii]),
            .i_round_key    (i_round_keys[ii]),
            .o_state        (state_bus[ii+1]),
            .o_data         (data_bus[ii+1]),
            .o_valid        (valid_bus[ii+1])
        );
    end

    assign o_state = state_bus[N_STAGES];
    assign o_valid = valid_bus[N_STAGES];

    // Keystream applied after the last register.
    assign o_data  = data_bus[N_STAGES] ^ state_bus[N_STAGES];

endmodule

/* verilog/aes_ctr_ladder.sv */
`timescale 1ns/100ps

module aes_ctr_ladder
(
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  aes_pkg::aes_key_t       i_key,
    input  logic                    i_key_load,
    output logic                    o_key_ready,
    input  aes_pkg::aes_block_t     i_state,
    input  aes_pkg::aes_block_t     i_data,
    input  logic                    i_valid,
    output aes_pkg::aes_block_t     o_state,
    output aes_pkg::aes_block_t     o_data,
    output logic                    o_valid
);

    import aes_pkg::*;

    aes_round_keys_t    round_keys;     // Held steady between commits.

    aes_key_expander u_key_expander
    (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_key          (i_key),
        .i_key_load     (i_key_load),
        .o_round_keys   (round_keys),
        .o_key_ready    (o_key_ready)
    );

    aes_round_ladder_xor_data u_round_ladder
    (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_state        (i_state),
        .i_data         (i_data),
        .i_valid        (i_valid),
        .i_round_keys   (round_keys),
        .o_state        (o_state),
        .o_data         (o_data),
        .o_valid        (o_valid)
    );

endmodule

/* test/aes_ctr_ladder_sva.sv */
`timescale 1ns/100ps

module aes_ctr_ladder_sva
(
    input  logic    i_clock,
    input  logic    i_rst_n,
    input  logic    i_key_load,
    input  logic    i_valid,
    input  logic    i_key_ready,
    input  logic    i_out_valid
);

    import aes_pkg::*;

    logic [N_STAGES-1:0]    valid_hist;     // Bit k is i_valid from k+1 cycles back.
    logic [4:0]             load_cnt;       // Cycles left until the key commit.

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            valid_hist <= '0;
            load_cnt   <= '0;
        end
        else
        begin
            valid_hist <= {valid_hist[N_STAGES-2:0], i_valid};
            if (i_key_load && load_cnt == 5'd0)
                load_cnt <= 5'd16;              // Expander idle, load taken.
            else if (load_cnt != 5'd0)
                load_cnt <= load_cnt - 5'd1;
        end
    end

    reset_clears_valid: assert property (@(posedge i_clock) !i_rst_n |-> !i_out_valid)
        else $error("o_valid high while reset is asserted");

    valid_latency: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_out_valid == valid_hist[N_STAGES-1])
        else $error("o_valid does not follow i_valid by fifteen cycles");

    // Commit lands on the sixteenth edge after the load.
    key_commit: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        load_cnt == 5'd1 |=> $rose(i_key_ready))
        else $error("o_key_ready did not rise sixteen cycles after a key load");

endmodule

bind aes_ctr_ladder aes_ctr_ladder_sva u_ctr_ladder_sva
(
    .i_clock        (i_clock),
    .i_rst_n        (i_rst_n),
    .i_key_load     (i_key_load),
    .i_valid        (i_valid),
    .i_key_ready    (o_key_ready),
    .i_out_valid    (o_valid)
);

/* include/aes_tb_model.svh */
`ifndef AES_TB_MODEL_SVH
`define AES_TB_MODEL_SVH

// GF(2^8) product by shift and add.
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    p = 8'h00;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
            p = p ^ a;
        a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

// S-box from the inverse x^254 and the affine map.
function automatic logic [7:0] calc_sbox(input logic [7:0] x);
    logic [7:0] sq;
    logic [7:0] inv;
    sq  = x;
    inv = 8'h01;
    for (int i = 1; i < 8; i++)
    begin
        sq  = gf_mul(sq, sq);
        inv = gf_mul(inv, sq);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
               ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

function automatic logic [127:0] aes256_encrypt(input logic [255:0] key,
                                                input logic [127:0] pt);
    logic [31:0]  w [0:59];
    logic [31:0]  t;
    logic [7:0]   s [0:15];
    logic [7:0]   u [0:15];
    logic [7:0]   rc;
    logic [127:0] ct;
    rc = 8'h01;
    for (int i = 0; i < 8; i++)
        w[i] = key[255-32*i -: 32];
    for (int i = 8; i < 60; i++)
    begin
        t = w[i-1];
        if (i % 8 == 0)
        begin
            t  = {calc_sbox(t[23:16]), calc_sbox(t[15:8]), calc_sbox(t[7:0]),
                  calc_sbox(t[31:24])} ^ {rc, 24'h0};
            rc = gf_mul(rc, 8'h02);
        end
        else if (i % 8 == 4)
            t = {calc_sbox(t[31:24]), calc_sbox(t[23:16]),
                 calc_sbox(t[15:8]), calc_sbox(t[7:0])};
        w[i] = w[i-8] ^ t;
    end
    for (int i = 0; i < 16; i++)
        s[i] = pt[127-8*i -: 8] ^ w[i/4][31-8*(i%4) -: 8];
    for (int r = 1; r < 15; r++)
    begin
        for (int i = 0; i < 16; i++)
            u[i] = calc_sbox(s[(i % 4) + 4 * (((i / 4) + (i % 4)) % 4)]);
        for (int c = 0; c < 4; c++)
        begin
            s[4*c]   = (r == 14) ? u[4*c] : gf_mul(u[4*c], 8'h02) ^ gf_mul(u[4*c+1], 8'h03)
                       ^ u[4*c+2] ^ u[4*c+3];
            s[4*c+1] = (r == 14) ? u[4*c+1] : u[4*c] ^ gf_mul(u[4*c+1], 8'h02)
                       ^ gf_mul(u[4*c+2], 8'h03) ^ u[4*c+3];
            s[4*c+2] = (r == 14) ? u[4*c+2] : u[4*c] ^ u[4*c+1] ^ gf_mul(u[4*c+2], 8'h02)
                       ^ gf_mul(u[4*c+3], 8'h03);
            s[4*c+3] = (r == 14) ? u[4*c+3] : gf_mul(u[4*c], 8'h03) ^ u[4*c+1] ^ u[4*c+2]
                       ^ gf_mul(u[4*c+3], 8'h02);
        end
        for (int i = 0; i < 16; i++)
            s[i] = s[i] ^ w[4*r + i/4][31-8*(i%4) -: 8];
    end
    for (int i = 0; i < 16; i++)
        ct[127-8*i -: 8] = s[i];
    return ct;
endfunction

`endif

/* test/tb_aes_ctr_ladder.sv */
`timescale 1ns/100ps

module tb_aes_ctr_ladder;

    import aes_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int KEY_LATENCY     = N_STAGES + 1;
    localparam int N_RANDOM        = 200;
    localparam int N_GAPPED        = 100;
    localparam int N_REKEY         = 50;
    localparam int N_FLIGHT        = 10;
    localparam int N_AFTER         = 20;
    localparam int MAX_GAP         = 32;      // Longest run of ones from the LFSR.
    localparam int N_KEY_LOADS     = 3;
    localparam int N_BLOCKS        = 1 + N_RANDOM + N_GAPPED + N_REKEY + N_FLIGHT + N_AFTER;
    localparam int WATCHDOG_CYCLES = N_BLOCKS + N_GAPPED * MAX_GAP
                                     + N_KEY_LOADS * KEY_LATENCY + 1000;

    logic           i_clock;
    logic           i_rst_n;
    aes_key_t       i_key;
    logic           i_key_load;
    logic           o_key_ready;
    aes_block_t     i_state;
    aes_block_t     i_data;
    logic           i_valid;
    aes_block_t     o_state;
    aes_block_t     o_data;
    logic           o_valid;

    logic [31:0]    lfsr_state;
    aes_key_t       model_key;
    aes_block_t     exp_state_q [$];
    aes_block_t     exp_data_q [$];
    int             in_cycle_q [$];
    int             cycle;
    string          test_name;

    `include "aes_tb_model.svh"

    aes_ctr_ladder dut_i
    (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_key          (i_key),
        .i_key_load     (i_key_load),
        .o_key_ready    (o_key_ready),
        .i_state        (i_state),
        .i_data         (i_data),
        .i_valid        (i_valid),
        .o_state        (o_state),
        .o_data         (o_data),
        .o_valid        (o_valid)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    always @(posedge i_clock)
    begin
        cycle <= cycle + 1;
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic random_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic aes_block_t random_block();
        aes_block_t blk;
        for (int i = 0; i < NB_STATE; i++)
            blk[i] = random_bit();
        return blk;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check(input string name, input aes_block_t expected, input aes_block_t actual);
        if (expected !== actual)
            stop_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    endtask

    // Output side, sampled half a cycle away from the driving edge.
    always @(negedge i_clock)
    begin
        if (!i_rst_n)
        begin
            in_cycle_q.delete();
            if (o_valid !== 1'b0 || o_key_ready !== 1'b0)
                stop_run("o_valid or o_key_ready high while reset is asserted");
        end
        else
        begin
            if (i_valid)
                in_cycle_q.push_back(cycle);
            if (o_valid && (exp_state_q.size() == 0 || in_cycle_q.size() == 0))
                stop_run("o_valid high with no block in flight");
            else if (o_valid)
            begin
                check({test_name, " latency"}, aes_block_t'(N_STAGES),
                      aes_block_t'(cycle - in_cycle_q.pop_front()));
                check({test_name, " o_state"}, exp_state_q.pop_front(), o_state);
                check({test_name, " o_data"}, exp_data_q.pop_front(), o_data);
            end
        end
    end

    task automatic apply_reset();
        @(posedge i_clock);
        i_rst_n    <= 1'b0;
        i_valid    <= 1'b0;
        i_key_load <= 1'b0;
        exp_state_q.delete();                   // Blocks in flight are lost.
        exp_data_q.delete();
        repeat (RESET_CYCLES) @(posedge i_clock);
        i_rst_n <= 1'b1;
    endtask

    task automatic drive_block(input aes_block_t state, input aes_block_t data,
                               input aes_block_t expected_state);
        @(posedge i_clock);
        i_state <= state;
        i_data  <= data;
        i_valid <= 1'b1;
        exp_state_q.push_back(expected_state);
        exp_data_q.push_back(data ^ expected_state);
    endtask

    task automatic drive_idle();
        @(posedge i_clock);
        i_valid <= 1'b0;
    endtask

    // Ready is low from the cycle after the load until the commit.
    task automatic load_key(input aes_key_t key);
        @(posedge i_clock);
        i_key      <= key;
        i_key_load <= 1'b1;
        model_key  = key;
        for (int k = 0; k <= KEY_LATENCY; k++)
        begin
            @(posedge i_clock);
            i_key_load <= 1'b0;
            @(negedge i_clock);
            check($sformatf("%s key_ready cycle %0d", test_name, k),
                  aes_block_t'(k == KEY_LATENCY), aes_block_t'(o_key_ready));
        end
    endtask

    task automatic send_random(input int n, input bit gapped);
        aes_block_t state;
        aes_block_t data;
        for (int b = 0; b < n; b++)
        begin
            while (gapped && random_bit())
                drive_idle();
            state = random_block();
            data  = random_block();
            drive_block(state, data, aes256_encrypt(model_key, state));
        end
        drive_idle();
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_state_q.size() != 0 && waited < 4 * N_STAGES)
        begin
            @(posedge i_clock);
            waited++;
        end
        if (exp_state_q.size() != 0)
            stop_run($sformatf("%s blocks still in flight after the drain time", test_name));
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_run("watchdog expired before the tests finished");
    end

    initial
    begin
        i_clock    = 1'b0;
        i_rst_n    = 1'b0;
        i_key      = '0;
        i_key_load = 1'b0;
        i_state    = '0;
        i_data     = '0;
        i_valid    = 1'b0;
        lfsr_state = 32'hba6f_c22f;
        cycle      = 0;
        model_key  = '0;
        test_name  = "reset";
        apply_reset();

        // FIPS-197 AES-256 example.
        test_name = "known_vector";
        load_key(256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f);
        drive_block(128'h00112233445566778899aabbccddeeff, '0,
                    128'h8ea2b7ca516745bfeafc49904b496089);
        drive_idle();
        wait_drain();

        test_name = "back_to_back";
        send_random(N_RANDOM, 1'b0);
        wait_drain();

        test_name = "gapped";
        send_random(N_GAPPED, 1'b1);
        wait_drain();

        test_name = "rekey";
        load_key({random_block(), random_block()});
        send_random(N_REKEY, 1'b0);
        wait_drain();

        test_name = "reset_mid_stream";
        send_random(N_FLIGHT, 1'b0);
        apply_reset();
        for (int k = 0; k < N_AFTER; k++)
        begin
            @(negedge i_clock);
            check({test_name, " key_ready after reset"}, '0, aes_block_t'(o_key_ready));
        end
        load_key({random_block(), random_block()});
        send_random(N_AFTER, 1'b0);
        wait_drain();

        if (exp_state_q.size() != 0 || in_cycle_q.size() != 0)
            stop_run("blocks left in the model queue at the end of the run");
        else
        begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

/* aes_ctr_ladder.f */
+incdir+include
verilog/aes_pkg.sv
verilog/aes_key_expander.sv
verilog/aes_round_stage.sv
verilog/aes_round_ladder_xor_data.sv
verilog/aes_ctr_ladder.sv
test/aes_ctr_ladder_sva.sv
test/tb_aes_ctr_ladder.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_aes_ctr_ladder
FILELIST   := aes_ctr_ladder.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run status is ignored here; the log search decides pass or fail.
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
